/* hdl/delayLineAddr.sv */
`timescale 1ns/100ps

module delayLineAddr import firPkg::*; (
    input  logic      iClk,
    input  logic      iRst,
    input  sliceCtrlT sliceCtrl,
    input  logic      commit,        // New sample goes in this cycle
    output tapAddrT   wrAddr,        // Slot for the incoming sample
    output tapAddrT   rdAddr         // Sample read for the current tap
);

    tapAddrT head;                   // Address of the newest sample
    tapAddrT headNow;                // Head as seen by this cycle's read

    ////////////////////////////////////////////////////////////////////////////
    // Circular buffer head
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            head <= '0;
        end else if (commit) begin
            head <= wrAddr;          // Newest sample moves one slot on
        end
    end

    // Push goes one past the head, oldest sample is overwritten
    assign wrAddr = head + tapAddrT'(1);

    // Commit lands on slice 0 of a frame
    // Bypass the head so the whole frame sees the new sample
    assign headNow = commit ? wrAddr : head;

    // Tap k reads x[n-k], wraps modulo FIR_TAPS
    assign rdAddr = headNow - sliceCtrl.slice;

endmodule

/* hdl/firAccumulator.sv */
`timescale 1ns/100ps
`include "fir_params.svh"

module firAccumulator import firPkg::*; (
    input  logic      iClk,
    input  logic      iRst,
    input  sliceCtrlT sliceCtrl,     // Same cycle as the RAM read addresses
    input  logic      commit,        // Delay line written in the update slot
    input  coefT      coef,          // Coefficient RAM data
    input  sampleT    sample,        // Delay line data
    output sampleT    oData,
    output logic      oDataChanged   // Flips one cycle after oData moves
);

    sliceCtrlT ctrlPs1;
    sliceCtrlT ctrlPs2;              // Aligned with RAM read data
    sliceCtrlT ctrlPs3;              // Aligned with the product
    accT       prodPs3;
    accT       accPs4;
    logic      commitSeen;           // Commit since the last update slot
    logic      armed;                // Current frame includes a new sample
    logic      frameEndPs4;          // Final sum sits in accPs4
    logic      outChangedPs5;

    ////////////////////////////////////////////////////////////////////////////
    // Control pipeline and fresh-result tracking
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            ctrlPs1     <= '0;
            ctrlPs2     <= '0;
            ctrlPs3     <= '0;
            commitSeen  <= 1'b0;
            armed       <= 1'b0;
            frameEndPs4 <= 1'b0;
        end else begin
            ctrlPs1 <= sliceCtrl;
            ctrlPs2 <= ctrlPs1;
            ctrlPs3 <= ctrlPs2;
            if (ctrlPs3.doUpdate) begin
                armed      <= commitSeen;   // Next frame reads the new sample
                commitSeen <= commit;
            end else if (commit) begin
                commitSeen <= 1'b1;
            end
            frameEndPs4 <= ctrlPs3.lastTap && armed;   // Uses the old armed
        end
    end

    // MAC, product stage then accumulate with first tap restart
    always_ff @(posedge iClk) begin
        prodPs3 <= accT'(coef) * accT'(sample);
        if (ctrlPs3.firstTap) begin
            accPs4 <= prodPs3;
        end else begin
            accPs4 <= accPs4 + prodPs3;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register, then the toggle one cycle later
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            oData         <= '0;
            outChangedPs5 <= 1'b0;
            oDataChanged  <= 1'b0;
        end else begin
            outChangedPs5 <= frameEndPs4;
            if (frameEndPs4) begin
                oData <= sampleT'(accPs4[`FIR_OUT_LSB +: `FIR_SAMPLE_W]);
            end
            if (outChangedPs5) begin
                oDataChanged <= ~oDataChanged;   // Edge while oData is stable
            end
        end
    end

endmodule

/* hdl/firEngine.sv */
`timescale 1ns/100ps

module firEngine import firPkg::*; (
    input  logic   iClk,
    input  logic   iRst,
    input  sampleT iData,
    input  logic   iDataChanged,     // Toggle per new sample
    input  coefWrT iCoefWr,          // Coefficient write strobe
    output sampleT oData,
    output logic   oDataChanged      // Toggle per new output
);

    sliceCtrlT sliceCtrl;            // One slice per clock
    logic      commit;
    sampleT    commitSample;
    tapAddrT   dlWrAddr;
    tapAddrT   dlRdAddr;
    coefT      coefRd;               // Coefficient for the tap in flight
    sampleT    sampleRd;             // Delay line sample for the tap in flight

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    sliceSequencer i_sliceSequencer (
        .iClk      (iClk),
        .iRst      (iRst),
        .sliceCtrl (sliceCtrl)
    );

    sampleCapture i_sampleCapture (
        .iClk         (iClk),
        .iRst         (iRst),
        .iData        (iData),
        .iDataChanged (iDataChanged),
        .sliceCtrl    (sliceCtrl),
        .commit       (commit),
        .commitSample (commitSample)
    );

    delayLineAddr i_delayLineAddr (
        .iClk      (iClk),
        .iRst      (iRst),
        .sliceCtrl (sliceCtrl),
        .commit    (commit),
        .wrAddr    (dlWrAddr),
        .rdAddr    (dlRdAddr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage and MAC
    ////////////////////////////////////////////////////////////////////////////
    tapRam #(.payloadT(coefT)) i_coefRam (
        .iClk   (iClk),
        .wrEn   (iCoefWr.wrEn),
        .wrAddr (iCoefWr.wrAddr),
        .wrData (iCoefWr.wrData),
        .rdAddr (sliceCtrl.slice),   // Tap k uses coef[k]
        .rdData (coefRd)
    );

    tapRam #(.payloadT(sampleT)) i_delayRam (
        .iClk   (iClk),
        .wrEn   (commit),
        .wrAddr (dlWrAddr),
        .wrData (commitSample),
        .rdAddr (dlRdAddr),
        .rdData (sampleRd)
    );

    firAccumulator i_firAccumulator (
        .iClk         (iClk),
        .iRst         (iRst),
        .sliceCtrl    (sliceCtrl),
        .commit       (commit),
        .coef         (coefRd),
        .sample       (sampleRd),
        .oData        (oData),
        .oDataChanged (oDataChanged)
    );

endmodule

/* hdl/firPkg.sv */
`include "fir_params.svh"

package firPkg;

    // Datapath words
    typedef logic signed [`FIR_SAMPLE_W-1:0] sampleT;  // Delay line sample
    typedef logic signed [`FIR_SAMPLE_W-1:0] coefT;    // Filter coefficient
    typedef logic signed [`FIR_ACC_W-1:0]    accT;     // MAC accumulator

    // Address into delay line or coefficient RAM
    typedef logic [`FIR_ADDR_W-1:0] tapAddrT;

    // Per-slice control word, one value per clock
    typedef struct packed {
        tapAddrT slice;     // Current time slice
        logic    firstTap;  // Restart accumulation
        logic    lastTap;   // Final tap of the frame
        logic    doUpdate;  // Update slot for the delay line
    } sliceCtrlT;

    // Coefficient RAM write strobe
    typedef struct packed {
        logic    wrEn;      // Single cycle write enable
        tapAddrT wrAddr;    // Tap index
        coefT    wrData;    // New coefficient
    } coefWrT;

endpackage

/* hdl/fir_params.svh */
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// Sample and coefficient width
`define FIR_SAMPLE_W 18

// Taps per frame, one slice per tap
`define FIR_TAPS 32

// RAM address width, log2 of FIR_TAPS
`define FIR_ADDR_W 5

// MAC accumulator width
`define FIR_ACC_W 48

// Output taken from accumulator bits [FIR_OUT_LSB+FIR_SAMPLE_W-1 : FIR_OUT_LSB]
`define FIR_OUT_LSB 16

// Cycles after reset with the update slot held off
`define FIR_UPDATE_HOLDOFF 4

`endif

/* hdl/sampleCapture.sv */
`timescale 1ns/100ps

module sampleCapture import firPkg::*; (
    input  logic      iClk,
    input  logic      iRst,
    input  sampleT    iData,         // Sample, valid before the toggle
    input  logic      iDataChanged,  // Flips once per new sample
    input  sliceCtrlT sliceCtrl,
    output logic      commit,        // One cycle write strobe for the delay line
    output sampleT    commitSample   // Sample written on commit
);

    logic   toggleLvl;               // Registered toggle level
    logic   doneLvl;                 // Toggle level already committed
    logic   pending;                 // New sample waiting for the update slot
    sampleT heldSample;              // Last sample seen

    assign pending = toggleLvl ^ doneLvl;

    // Toggle tracking and commit strobe
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            toggleLvl <= 1'b0;
            doneLvl   <= 1'b0;
            commit    <= 1'b0;
        end else begin
            toggleLvl <= iDataChanged;
            commit    <= 1'b0;
            if (sliceCtrl.doUpdate) begin
                commit  <= pending;      // Only when something arrived
                doneLvl <= toggleLvl;    // Flag cleared
            end
        end
    end

    // Sample latch, later toggles in a frame overwrite earlier ones
    always_ff @(posedge iClk) begin
        if (iDataChanged != toggleLvl) begin
            heldSample <= iData;
        end
        if (sliceCtrl.doUpdate) begin
            commitSample <= heldSample;  // Frozen for the write cycle
        end
    end

endmodule

/* hdl/sliceSequencer.sv */
`timescale 1ns/100ps
`include "fir_params.svh"

module sliceSequencer import firPkg::*; (
    input  logic      iClk,
    input  logic      iRst,
    output sliceCtrlT sliceCtrl      // Control for the current slice
);

    localparam int holdW = $clog2(`FIR_UPDATE_HOLDOFF + 1);

    logic [holdW-1:0] holdCnt;       // Cycles since reset, saturating
    logic             holdDone;
    tapAddrT          nextSlice;
    logic             nextLast;

    assign nextSlice = sliceCtrl.slice + tapAddrT'(1);   // Wraps modulo FIR_TAPS
    assign nextLast  = (nextSlice == tapAddrT'(`FIR_TAPS - 1));
    assign holdDone  = (holdCnt == holdW'(`FIR_UPDATE_HOLDOFF));

    ////////////////////////////////////////////////////////////////////////////
    // Slice counter with flags decoded from the next count
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            sliceCtrl.slice    <= '0;
            sliceCtrl.firstTap <= 1'b1;    // Slice 0 follows reset
            sliceCtrl.lastTap  <= 1'b0;
            sliceCtrl.doUpdate <= 1'b0;
            holdCnt            <= '0;
        end else begin
            sliceCtrl.slice    <= nextSlice;
            sliceCtrl.firstTap <= (nextSlice == '0);
            sliceCtrl.lastTap  <= nextLast;
            // Update slot shares the last tap, but not while held off
            sliceCtrl.doUpdate <= nextLast && holdDone;
            if (!holdDone) begin
                holdCnt <= holdCnt + holdW'(1);
            end
        end
    end

endmodule

/* hdl/tapRam.sv */
`timescale 1ns/100ps
`include "fir_params.svh"

module tapRam import firPkg::*; #(
    parameter type payloadT = sampleT    // Word stored per tap
) (
    input  logic    iClk,
    input  logic    wrEn,
    input  tapAddrT wrAddr,
    input  payloadT wrData,
    input  tapAddrT rdAddr,
    output payloadT rdData              // Two cycles after rdAddr
);

    payloadT mem [0:`FIR_TAPS-1];
    payloadT rdStage;                   // First read register

    ////////////////////////////////////////////////////////////////////////////
    // Write port and registered read with write-through
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        // Same address written this cycle returns the new word
        if (wrEn && (wrAddr == rdAddr)) begin
            rdStage <= wrData;
        end else begin
            rdStage <= mem[rdAddr];
        end
        rdData <= rdStage;              // Second register
    end

endmodule

/* project.f */
+incdir+hdl
hdl/firPkg.sv
hdl/sliceSequencer.sv
hdl/sampleCapture.sv
hdl/tapRam.sv
hdl/delayLineAddr.sv
hdl/firAccumulator.sv
hdl/firEngine.sv
tests/firEngine_props.sv
tests/firEngineTb.sv

/* run.sh */
#!/bin/sh
# Build and run the FIR engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module firEngineTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VfirEngineTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Testbench passed"; then
    exit 0
fi
exit 1

/* tests/firEngineTb.sv */
`timescale 1ns/100ps
`include "fir_params.svh"

module firEngineTb import firPkg::*; ();

    localparam int toggleTimeout = 200;  // Cycles allowed per output toggle
    localparam int patDepth      = 256;

    logic        iClk;
    logic        iRst;
    sampleT      iData;
    logic        iDataChanged;
    coefWrT      iCoefWr;
    sampleT      oData;
    logic        oDataChanged;

    logic [31:0] pat [0:patDepth-1];    // Pattern words with three per record
    int          sentCount;             // Input toggles issued
    int          flipCount;             // Output toggles observed
    logic        outPrev;

    firEngine i_firEngine (
        .iClk         (iClk),
        .iRst         (iRst),
        .iData        (iData),
        .iDataChanged (iDataChanged),
        .iCoefWr      (iCoefWr),
        .oData        (oData),
        .oDataChanged (oDataChanged)
    );

    initial begin
        iClk = 1'b0;
        forever #2 iClk = ~iClk;         // 4 ns period
    end

    // Count output toggles outside reset
    always @(posedge iClk) begin
        outPrev <= oDataChanged;
        if (!iRst && (oDataChanged != outPrev)) begin
            flipCount <= flipCount + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [47:0] got,
                              input logic [47:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic writeCoef(input tapAddrT addr, input coefT data);
        @(posedge iClk);
        iCoefWr <= '{wrEn: 1'b1, wrAddr: addr, wrData: data};
        @(posedge iClk);
        iCoefWr <= '0;                   // Single cycle strobe
    endtask

    task automatic waitOutputToggle();
        int   cycles;
        logic startLvl;
        cycles   = 0;
        startLvl = oDataChanged;
        while (oDataChanged == startLvl) begin
            @(posedge iClk);
            cycles++;
            if (cycles > toggleTimeout) begin
                $display("timeout: no output toggle within %0d cycles", toggleTimeout);
                $display("Testbench failed");
                $fatal(1);
            end
        end
    endtask

    // One sample in and one result out
    task automatic sendSample(input sampleT s);
        @(posedge iClk);
        iData        <= s;
        iDataChanged <= ~iDataChanged;
        sentCount++;
        waitOutputToggle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int   rec;
        logic lvl;
        iRst         = 1'b1;
        iData        = '0;
        iDataChanged = 1'b0;
        iCoefWr      = '0;
        sentCount    = 0;
        flipCount    = 0;
        outPrev      = 1'b0;
        $readmemh("tests/firEngine_patterns.txt", pat);
        repeat (10) @(posedge iClk);
        iRst <= 1'b0;
        @(posedge iClk);
        checkValue("oData", 48'(oData), 48'(0));
        checkValue("oDataChanged", 48'(oDataChanged), 48'(0));

        rec = 0;
        while ((rec + 2 < patDepth) && (pat[rec] != 32'd0)) begin
            case (pat[rec])
                32'd1: writeCoef(tapAddrT'(pat[rec+1]), coefT'(pat[rec+2]));
                32'd2: begin
                    for (int i = 0; i < int'(pat[rec+1]); i++) begin
                        sendSample('0);  // Result ignored
                    end
                end
                32'd3: begin
                    sendSample(sampleT'(pat[rec+1]));
                    checkValue("oData", 48'(oData), 48'(sampleT'(pat[rec+2])));
                end
                32'd4: begin
                    for (int k = 0; k < `FIR_TAPS; k++) begin
                        writeCoef(tapAddrT'(k), '0);
                    end
                end
                default: begin
                    $display("unknown record kind %0d in pattern file", pat[rec]);
                    $display("Testbench failed");
                    $fatal(1);
                end
            endcase
            rec += 3;
        end

        // Records must stop at the end record after some samples
        if ((sentCount == 0) || (rec + 2 >= patDepth) || (pat[rec] !== 32'd0)) begin
            $display("pattern file is missing, holds no samples or lacks its end record");
            $display("Testbench failed");
            $fatal(1);
        end

        // Quiet input must leave the toggle alone
        lvl = oDataChanged;
        for (int i = 0; i < 100; i++) begin
            @(posedge iClk);
            checkValue("oDataChanged", 48'(oDataChanged), 48'(lvl));
        end
        checkValue("flipCount", 48'(flipCount), 48'(sentCount));

        $display("Testbench passed");
        $finish;
    end

endmodule

/* tests/firEngine_patterns.txt */
// Records of three hex words: kind argA argB
// 1 = coef write (addr data), 2 = flush (count 0), 3 = sample (data expected), 4 = clear coefs, 0 = end
4 0 0
1 00 00003
1 01 3FFFE
1 02 00005
1 03 00001
2 20 0
3 10000 00003  3 00000 3FFFE  3 00000 00005  3 00000 00001
3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0
3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0
3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0
3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0  3 0 0
3 08000 00001
3 30000 3FFFC
3 186A0 00009
3 3FFFF 3FFF8
1 00 3FFFC
1 01 00007
3 10000 00002
3 00000 00008
0 0 0

/* tests/firEngine_props.sv */
`timescale 1ns/100ps

module firEngineProps import firPkg::*; (
    input logic   iClk,
    input logic   iRst,
    input sampleT oData,
    input logic   oDataChanged
);

    logic [5:0] sinceFlip;           // Saturating count of cycles since the last toggle
    logic       prevLvl;             // Toggle level one clock earlier

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            sinceFlip <= 6'd40;
            prevLvl   <= 1'b0;
        end else begin
            prevLvl <= oDataChanged;
            if (oDataChanged != prevLvl) begin
                sinceFlip <= 6'd1;
            end else if (sinceFlip != 6'd63) begin
                sinceFlip <= sinceFlip + 6'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output toggle protocol
    ////////////////////////////////////////////////////////////////////////////
    stableOnFlip: assert property (@(posedge iClk) disable iff (iRst)
        $changed(oDataChanged) |-> $stable(oData))
        else $error("oData moved in the toggle cycle");

    oneFlipPerFrame: assert property (@(posedge iClk) disable iff (iRst)
        $changed(oDataChanged) |-> (sinceFlip >= 6'd32))  // One frame apart at least
        else $error("oDataChanged flipped twice within a frame");

    lowInReset: assert property (@(posedge iClk) iRst |-> !oDataChanged)
        else $error("oDataChanged high during reset");

endmodule

bind firAccumulator firEngineProps i_firEngineProps (
    .iClk         (iClk),
    .iRst         (iRst),
    .oData        (oData),
    .oDataChanged (oDataChanged)
);
